// File: md5Pkg.sv
package md5Pkg;

  typedef logic [31:0] word_t;
  typedef logic [511:0] block_t;

  localparam int NumSteps = 64;
  localparam int StepsPerRound = 16;
  localparam int WordsPerBlock = 16;

  // per-step additive constants, floor(abs(sin(i + 1)) * 2^32).
  localparam word_t stepConst [NumSteps] = '{
    32'hd76a_a478, 32'he8c7_b756, 32'h2420_70db, 32'hc1bd_ceee,
    32'hf57c_0faf, 32'h4787_c62a, 32'ha830_4613, 32'hfd46_9501,
    32'h6980_98d8, 32'h8b44_f7af, 32'hffff_5bb1, 32'h895c_d7be,
    32'h6b90_1122, 32'hfd98_7193, 32'ha679_438e, 32'h49b4_0821,
    32'hf61e_2562, 32'hc040_b340, 32'h265e_5a51, 32'he9b6_c7aa,
    32'hd62f_105d, 32'h0244_1453, 32'hd8a1_e681, 32'he7d3_fbc8,
    32'h21e1_cde6, 32'hc337_07d6, 32'hf4d5_0d87, 32'h455a_14ed,
    32'ha9e3_e905, 32'hfcef_a3f8, 32'h676f_02d9, 32'h8d2a_4c8a,
    32'hfffa_3942, 32'h8771_f681, 32'h6d9d_6122, 32'hfde5_380c,
    32'ha4be_ea44, 32'h4bde_cfa9, 32'hf6bb_4b60, 32'hbebf_bc70,
    32'h289b_7ec6, 32'heaa1_27fa, 32'hd4ef_3085, 32'h0488_1d05,
    32'hd9d4_d039, 32'he6db_99e5, 32'h1fa2_7cf8, 32'hc4ac_5665,
    32'hf429_2244, 32'h432a_ff97, 32'hab94_23a7, 32'hfc93_a039,
    32'h655b_59c3, 32'h8f0c_cc92, 32'hffef_f47d, 32'h8584_5dd1,
    32'h6fa8_7e4f, 32'hfe2c_e6e0, 32'ha301_4314, 32'h4e08_11a1,
    32'hf753_7e82, 32'hbd3a_f235, 32'h2ad7_d2bb, 32'heb86_d391
  };

  // left rotate amounts, four per round repeated.
  localparam int stepShift [NumSteps] = '{
    7, 12, 17, 22,
    7, 12, 17, 22,
    7, 12, 17, 22,
    7, 12, 17, 22,
    5, 9, 14, 20,
    5, 9, 14, 20,
    5, 9, 14, 20,
    5, 9, 14, 20,
    4, 11, 16, 23,
    4, 11, 16, 23,
    4, 11, 16, 23,
    4, 11, 16, 23,
    6, 10, 15, 21,
    6, 10, 15, 21,
    6, 10, 15, 21,
    6, 10, 15, 21
  };

  // round 0..3 picks F, G, H or I.
  function automatic int roundOf(input int step);
    return step / StepsPerRound;
  endfunction

  // message word consumed by a step.
  function automatic int wordIndexOf(input int step);
    int idx;
    case (roundOf(step))
      0:
      begin
        idx = step;
      end
      1:
      begin
        idx = (5 * step + 1) % WordsPerBlock;
      end
      2:
      begin
        idx = (3 * step + 5) % WordsPerBlock;
      end
      default:
      begin
        idx = (7 * step) % WordsPerBlock;
      end
    endcase
    return idx;
  endfunction

endpackage

// File: md5StageIf.sv
`timescale 1ns/100ps

interface md5StageIf;
  import md5Pkg::*;

  // chaining state between two steps.
  word_t a;
  word_t b;
  word_t c;
  word_t d;
  block_t block; // word 0 in the low bits.

  modport src (
    output a,
    output b,
    output c,
    output d,
    output block
  );

  modport dst (
    input a,
    input b,
    input c,
    input d,
    input block
  );

endinterface

// File: md5Step.sv
`timescale 1ns/100ps

module md5Step #(
  parameter int StepIndex = 0
) (
  input logic clk,
  input logic rstN,
  md5StageIf.dst prev,
  md5StageIf.src next
);
  import md5Pkg::*;

  localparam int RoundNum = roundOf(StepIndex);
  localparam int WordIdx = wordIndexOf(StepIndex);
  localparam int RotateAmt = stepShift[StepIndex];
  localparam word_t AddConst = stepConst[StepIndex];

  word_t msgWord [WordsPerBlock];
  word_t mix;
  word_t sum;
  word_t rotated;
  word_t newB;

  // split the block into its 16 words.
  always_comb
  begin
    for (int i = 0; i < WordsPerBlock; i++)
    begin
      msgWord[i] = prev.block[i*32 +: 32];
    end
  end

  // round function.
  always_comb
  begin
    case (RoundNum)
      0:
      begin
        mix = (prev.b & prev.c) | (~prev.b & prev.d); // F.
      end
      1:
      begin
        mix = (prev.d & prev.b) | (~prev.d & prev.c); // G.
      end
      2:
      begin
        mix = prev.b ^ prev.c ^ prev.d; // H.
      end
      default:
      begin
        mix = prev.c ^ (prev.b | ~prev.d); // I.
      end
    endcase
  end

  always_comb
  begin
    sum = prev.a + mix + AddConst + msgWord[WordIdx]; // mod 2^32.
    rotated = (sum << RotateAmt) | (sum >> (32 - RotateAmt));
    newB = prev.b + rotated;
  end

  // state moves one place and the block follows along.
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      next.a <= '0;
      next.b <= '0;
      next.c <= '0;
      next.d <= '0;
      next.block <= '0;
    end
    else
    begin
      next.a <= prev.d;
      next.b <= newB;
      next.c <= prev.b;
      next.d <= prev.c;
      next.block <= prev.block;
    end
  end

endmodule

// File: md5Core.sv
`timescale 1ns/100ps

module md5Core (
  input logic clk,
  input logic rstN,
  input md5Pkg::block_t block,
  input md5Pkg::word_t aIn,
  input md5Pkg::word_t bIn,
  input md5Pkg::word_t cIn,
  input md5Pkg::word_t dIn,
  output md5Pkg::word_t aOut,
  output md5Pkg::word_t bOut,
  output md5Pkg::word_t cOut,
  output md5Pkg::word_t dOut
);
  import md5Pkg::*;

  // stage 0 is the input, stage NumSteps the result.
  md5StageIf stage [NumSteps+1] ();

  assign stage[0].a = aIn;
  assign stage[0].b = bIn;
  assign stage[0].c = cIn;
  assign stage[0].d = dIn;
  assign stage[0].block = block;

  for (genvar i = 0; i < NumSteps; i++)
  begin : stepGen
    md5Step #(
      .StepIndex(i)
    ) stepInst (
      .clk(clk),
      .rstN(rstN),
      .prev(stage[i].dst),
      .next(stage[i+1].src)
    );
  end

  // raw state after step 64, no final add.
  assign aOut = stage[NumSteps].a;
  assign bOut = stage[NumSteps].b;
  assign cOut = stage[NumSteps].c;
  assign dOut = stage[NumSteps].d;

endmodule

// File: md5CoreSva.sv
`timescale 1ns/100ps

module md5CoreSva (
  input logic clk,
  input logic rstN,
  input md5Pkg::block_t block,
  input md5Pkg::word_t aIn,
  input md5Pkg::word_t bIn,
  input md5Pkg::word_t cIn,
  input md5Pkg::word_t dIn,
  input md5Pkg::word_t aOut,
  input md5Pkg::word_t bOut,
  input md5Pkg::word_t cOut,
  input md5Pkg::word_t dOut
);
  import md5Pkg::*;

  logic [639:0] inNow;
  logic [639:0] inPrev;
  logic [127:0] outNow;
  int filled;
  int stableCount;
  bit inReset;

  assign inNow = {block, aIn, bIn, cIn, dIn};
  assign outNow = {aOut, bOut, cOut, dOut};

  always_ff @(posedge clk)
  begin
    inReset <= !rstN;
  end

  // cycles since reset release, saturating.
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      filled <= 0;
    end
    else if (filled < NumSteps)
    begin
      filled <= filled + 1;
    end
  end

  // run length of unchanged inputs.
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      stableCount <= 0;
      inPrev <= '0;
    end
    else
    begin
      inPrev <= inNow;
      if (inNow === inPrev)
      begin
        if (stableCount <= NumSteps)
        begin
          stableCount <= stableCount + 1;
        end
      end
      else
      begin
        stableCount <= 0;
      end
    end
  end

  noUnknownOut: assert property (@(posedge clk) disable iff (!rstN)
    (filled >= NumSteps) |-> !$isunknown(outNow))
    else $error("outputs carry X or Z once the pipeline is full");

  zeroInReset: assert property (@(posedge clk)
    (!rstN && inReset) |-> (outNow == '0))
    else $error("outputs are not zero while reset is held");

  stableOut: assert property (@(posedge clk) disable iff (!rstN)
    (stableCount > NumSteps) |-> $stable(outNow))
    else $error("outputs changed although the inputs were held for a full pipeline");

endmodule

// File: md5CoreTb.sv
`timescale 1ns/100ps

module md5CoreTb;
  import md5Pkg::*;

  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 4;
  localparam int RandomItems = 200;
  localparam int HeldItems = 100;
  localparam int TotalItems = 2 + RandomItems + HeldItems + WordsPerBlock;
  localparam int TimeoutNs = (TotalItems + NumSteps + 20) * ClkPeriod;
  localparam int NumTests = 5;
  localparam logic [127:0] InitState =
    {32'h6745_2301, 32'hefcd_ab89, 32'h98ba_dcfe, 32'h1032_5476};
  // digests of "" and "abc" as little-endian words.
  localparam logic [127:0] EmptyDigest =
    {32'hd98c_1dd4, 32'h04b2_008f, 32'h9809_80e9, 32'h7e42_f8ec};
  localparam logic [127:0] AbcDigest =
    {32'h9850_0190, 32'hb04f_d23c, 32'h7d3f_96d6, 32'h727f_e128};

  typedef struct {
    int testId;
    int itemNo;
    int due;
    logic [127:0] expected;
  } pending_t;

  logic clk;
  logic rstN;
  block_t block;
  word_t aIn;
  word_t bIn;
  word_t cIn;
  word_t dIn;
  word_t aOut;
  word_t bOut;
  word_t cOut;
  word_t dOut;

  pending_t pendQ [$];
  string testName [NumTests] = '{"emptyMsg", "abcMsg", "randomRun", "heldBlock", "singleBit"};
  int testDriven [NumTests];
  int testPending [NumTests];
  int testErrors [NumTests];
  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  logic [31:0] rngState = 32'hbe94_af97;

  md5Core DUT (
    .clk(clk),
    .rstN(rstN),
    .block(block),
    .aIn(aIn),
    .bIn(bIn),
    .cIn(cIn),
    .dIn(dIn),
    .aOut(aOut),
    .bOut(bOut),
    .cOut(cOut),
    .dOut(dOut)
  );

  bind md5Core md5CoreSva sva (
    .clk(clk),
    .rstN(rstN),
    .block(block),
    .aIn(aIn),
    .bIn(bIn),
    .cIn(cIn),
    .dIn(dIn),
    .aOut(aOut),
    .bOut(bOut),
    .cOut(cOut),
    .dOut(dOut)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
  end

  function automatic word_t rotl(input word_t x, input int s);
    return (x << s) | (x >> (32 - s));
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // raw state after all 64 steps, no feed-forward.
  function automatic logic [127:0] md5Ref(input block_t blk, input logic [127:0] state);
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t f;
    word_t sum;
    word_t tmp;
    int idx;
    {a, b, c, d} = state;
    for (int i = 0; i < NumSteps; i++)
    begin
      case (i / 16)
        0:
        begin
          f = (b & c) | (~b & d);
          idx = i;
        end
        1:
        begin
          f = (b & d) | (c & ~d);
          idx = (5 * i + 1) % 16;
        end
        2:
        begin
          f = b ^ c ^ d;
          idx = (3 * i + 5) % 16;
        end
        default:
        begin
          f = c ^ (b | ~d);
          idx = (7 * i) % 16;
        end
      endcase
      sum = a + f + stepConst[i] + blk[idx*32 +: 32];
      tmp = d;
      d = c;
      c = b;
      b = b + rotl(sum, stepShift[i]);
      a = tmp;
    end
    return {a, b, c, d};
  endfunction

  function automatic logic [127:0] addState(input logic [127:0] x, input logic [127:0] y);
    logic [127:0] r;
    for (int i = 0; i < 4; i++)
    begin
      r[i*32 +: 32] = x[i*32 +: 32] + y[i*32 +: 32];
    end
    return r;
  endfunction

  task automatic drawWord(output word_t w);
    rngState = xorshift(rngState);
    w = rngState;
  endtask

  task automatic randomBlock(output block_t blk);
    word_t w;
    for (int i = 0; i < WordsPerBlock; i++)
    begin
      drawWord(w);
      blk[i*32 +: 32] = w;
    end
  endtask

  task automatic randomState(output logic [127:0] st);
    word_t w;
    for (int i = 0; i < 4; i++)
    begin
      drawWord(w);
      st[i*32 +: 32] = w;
    end
  endtask

  task automatic checkValue(input string name, input logic [127:0] expected,
                            input logic [127:0] actual, output bit ok);
    checkCount++;
    ok = (actual === expected);
    if (!ok)
    begin
      errorCount++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // reference model against the published digests.
  task automatic checkKnownDigests(input block_t emptyBlk, input block_t abcBlk);
    bit ok;
    int bad;
    bad = 0;
    checkValue("emptyDigest", EmptyDigest, addState(md5Ref(emptyBlk, InitState), InitState), ok);
    bad += !ok;
    checkValue("abcDigest", AbcDigest, addState(md5Ref(abcBlk, InitState), InitState), ok);
    bad += !ok;
    $display("test knownDigest done: 2 checked, %0d errors", bad);
  endtask

  task automatic driveItem(input int testId, input block_t blk, input logic [127:0] state);
    pending_t item;
    @(negedge clk);
    block = blk;
    {aIn, bIn, cIn, dIn} = state;
    item.testId = testId;
    item.itemNo = testDriven[testId];
    item.due = cycleCount + NumSteps; // lands after 64 rising edges.
    item.expected = md5Ref(blk, state);
    testDriven[testId]++;
    testPending[testId]++;
    pendQ.push_back(item);
  endtask

  task automatic compareDue();
    pending_t item;
    bit ok;
    while (pendQ.size() > 0 && pendQ[0].due == cycleCount)
    begin
      item = pendQ.pop_front();
      checkValue($sformatf("%s #%0d", testName[item.testId], item.itemNo),
                 item.expected, {aOut, bOut, cOut, dOut}, ok);
      if (!ok)
      begin
        testErrors[item.testId]++;
      end
      testPending[item.testId]--;
      if (testPending[item.testId] == 0)
      begin
        $display("test %s done: %0d checked, %0d errors", testName[item.testId],
                 testDriven[item.testId], testErrors[item.testId]);
      end
    end
  endtask

  always @(negedge clk)
  begin
    compareDue();
  end

  initial
  begin
    block_t blk;
    block_t emptyBlk;
    block_t abcBlk;
    logic [127:0] st;
    rstN = 1'b0;
    block = '0;
    aIn = '0;
    bIn = '0;
    cIn = '0;
    dIn = '0;
    emptyBlk = '0;
    emptyBlk[31:0] = 32'h0000_0080; // pad byte only.
    abcBlk = '0;
    abcBlk[31:0] = 32'h8063_6261;
    abcBlk[14*32 +: 32] = 32'd24; // length in bits.
    checkKnownDigests(emptyBlk, abcBlk);
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    driveItem(0, emptyBlk, InitState);
    driveItem(1, abcBlk, InitState);
    for (int i = 0; i < RandomItems; i++)
    begin
      randomBlock(blk);
      randomState(st);
      driveItem(2, blk, st);
    end
    randomBlock(blk);
    randomState(st);
    for (int i = 0; i < HeldItems; i++)
    begin
      driveItem(3, blk, st);
    end
    for (int w = 0; w < WordsPerBlock; w++)
    begin
      blk = '0;
      blk[w*32 + (7 * w + 3) % 32] = 1'b1;
      driveItem(4, blk, InitState);
    end
    while (pendQ.size() != 0)
    begin
      @(negedge clk);
    end
    $display("summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog.
  initial
  begin
    #(TimeoutNs);
    $display("timeout: %0d results still outstanding after %0d ns", pendQ.size(), TimeoutNs);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: md5Core.f
md5Pkg.sv
md5StageIf.sv
md5Step.sv
md5Core.sv
md5CoreSva.sv
md5CoreTb.sv
